// File: tb.f
+incdir+test
rtl/mxint_gelu_pkg.sv
rtl/gelu_stream_if.sv
rtl/mxint_gelu_csr.sv
rtl/gelu_approx.sv
rtl/mxint_gelu_element.sv
rtl/mxint_block_norm.sv
rtl/mxint_gelu_core.sv
rtl/mxint_gelu_top.sv
test/tb_mxint_gelu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mxint_gelu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_mxint_gelu_tasks.svh
task automatic check_eq(input string name, input longint got, input longint want);
    assert (got == want) else begin
        errors++;
        $display("Error: %s got 0x%0h expected 0x%0h", name, got, want);
    end
endtask

// tasks start and end just after a rising edge.
task automatic axi_write(input axi_addr_t a, input axi_data_t d, output axi_resp_t resp);
    awaddr  <= a;
    awvalid <= 1'b1;
    wdata   <= d;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    resp = bresp; // bready is held high.
    @(posedge clk);
endtask

task automatic axi_read(input axi_addr_t a, output axi_data_t d, output axi_resp_t resp);
    araddr  <= a;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    d    = rdata;
    resp = rresp;
    @(posedge clk);
endtask

task automatic set_enable(input bit en);
    axi_resp_t r;
    axi_write(ADDR_CTRL, axi_data_t'(en), r);
    check_eq("bresp", r, RESP_OKAY);
    gelu_on = en;
endtask

task automatic send_block(input man_block_t m, input exp_t e);
    in_valid <= 1'b1;
    in_mant  <= m;
    in_exp   <= e;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    push_expected(m, e); // taken at the coming edge.
    sent++;
    @(posedge clk);
endtask

task automatic idle();
    in_valid <= 1'b0;
endtask

task automatic wait_drain();
    while (want_mant_q.size() != 0) @(posedge clk);
endtask

// File: test/tb_mxint_gelu.sv
`timescale 1ns/1ps

module tb_mxint_gelu import mxint_gelu_pkg::*; ();

    // 150 random blocks at up to 8 cycles, directed blocks and register accesses, with margin.
    localparam int MAX_CYCLES = 4000;
    localparam int N_RANDOM   = 150;

    logic       clk = 1'b0;
    logic       arst_n;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    axi_resp_t  bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    axi_resp_t  rresp;
    logic       rvalid;
    logic       rready;
    logic       in_valid;
    logic       in_ready;
    man_block_t in_mant;
    exp_t       in_exp;
    logic       out_valid;
    logic       out_ready = 1'b1;
    man_block_t out_mant;
    exp_t       out_exp;

    int         errors = 0;
    int         cycles = 0;
    int         xfers  = 0;
    int         sent   = 0; // blocks accepted at the input.
    bit         gelu_on = 1'b1; // mirrors the enable bit.
    bit         rand_ready = 1'b0;
    man_block_t want_mant_q [$];
    exp_t       want_exp_q [$];

    always #50 clk = ~clk;

    mxint_gelu_top u_dut (.*);

    `include "tb_mxint_gelu_tasks.svh"

    always @(posedge clk) begin
        if (rand_ready) begin
            out_ready <= ($urandom_range(0, 1) == 1);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // outputs are compared at the falling edge, before the transfer edge.
    always @(negedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            assert (want_mant_q.size() != 0) else begin
                errors++;
                $display("Output block appeared with no block pending");
            end
            if (want_mant_q.size() != 0) begin
                check_eq("out_mant", out_mant, want_mant_q.pop_front());
                check_eq("out_exp", out_exp, want_exp_q.pop_front());
            end
            xfers++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d errors", cycles, errors);
            $display("Test failed");
            $finish;
        end
    end

    function automatic longint fx_of(int m, int e);
        longint v;
        if (e >= 0) begin
            v = longint'(m) * (longint'(1) << ((e > 20) ? 20 : e));
        end else begin
            v = longint'(m) >>> ((-e > 20) ? 20 : -e);
        end
        if (v > 32767) begin
            v = 32767;
        end else if (v < -32768) begin
            v = -32768;
        end
        return v;
    endfunction

    function automatic longint gelu_of(longint x);
        longint p;
        longint r;
        if (x <= -24) begin
            return 0;
        end
        if (x >= 24) begin
            return x;
        end
        p = x * (x + 24);
        r = ((p % 48) + 48) % 48; // floor needs a non-negative remainder.
        return (p - r) / 48;
    endfunction

    task automatic push_expected(input man_block_t m, input exp_t e);
        longint     res [BLOCK_SIZE];
        longint     s;
        int         ne;
        bit         fits;
        man_block_t om;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            res[i] = fx_of(int'(signed'(m[i*MAN_WIDTH +: MAN_WIDTH])), int'(e));
            if (gelu_on) begin
                res[i] = gelu_of(res[i]);
            end
        end
        ne = NORM_EXP_MAX;
        for (int k = NORM_EXP_MAX; k >= 0; k--) begin
            fits = 1'b1;
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                if (((res[i] >>> k) > 127) || ((res[i] >>> k) < -128)) begin
                    fits = 1'b0;
                end
            end
            if (fits) begin
                ne = k;
            end
        end
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            s = res[i] >>> ne;
            s = (s > 127) ? 127 : ((s < -128) ? -128 : s);
            om[i*MAN_WIDTH +: MAN_WIDTH] = s[MAN_WIDTH-1:0];
        end
        want_mant_q.push_back(om);
        want_exp_q.push_back(exp_t'(ne));
    endtask

    task automatic test_registers();
        axi_data_t d;
        axi_resp_t r;
        axi_read(ADDR_CTRL, d, r);
        check_eq("rdata", d, 32'h1);
        check_eq("rresp", r, RESP_OKAY);
        axi_read(ADDR_COUNT, d, r);
        check_eq("rdata", d, 32'h0);
        axi_write(ADDR_CTRL, 32'h3, r);
        check_eq("bresp", r, RESP_OKAY);
        axi_read(ADDR_CTRL, d, r);
        check_eq("rdata", d, 32'h1); // clear bit is not stored.
        axi_write(ADDR_CTRL, 32'h0, r);
        axi_read(ADDR_CTRL, d, r);
        check_eq("rdata", d, 32'h0);
        axi_write(ADDR_CTRL, 32'h1, r);
        axi_read(ADDR_CTRL, d, r);
        check_eq("rdata", d, 32'h1);
        axi_write(4'h8, 32'h1, r);
        check_eq("bresp", r, RESP_SLVERR);
        axi_read(4'h8, d, r);
        check_eq("rdata", d, 32'h0);
        check_eq("rresp", r, RESP_SLVERR);
    endtask

    task automatic test_bypass();
        set_enable(1'b0);
        send_block(32'h80_05_ec_0a, -8'sd2);
        send_block(32'h02_00_ff_01, 8'sd20); // fx saturates.
        send_block(32'h01_40_80_7f, 8'sd8);  // needs exponent 8.
        send_block(32'h10_f0_7f_81, 8'sd0);
        send_block(32'h00_00_00_7f, -8'sd9);
        idle();
        wait_drain();
    endtask

    task automatic test_gelu();
        set_enable(1'b1);
        send_block(32'h00_e9_e8_e7, 8'sd0); // lower knee.
        send_block(32'hff_19_18_17, 8'sd0); // upper knee.
        send_block(32'h06_fd_fa_f4, 8'sd0);
        send_block(32'h32_0c_9c_64, 8'sd0);
        send_block(32'hf9_05_fa_06, 8'sd2);
        idle();
        wait_drain();
    endtask

    task automatic test_stream();
        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle();
                @(posedge clk);
            end
            send_block($urandom, exp_t'(int'($urandom_range(0, 24)) - 12));
        end
        idle();
        wait_drain();
        rand_ready = 1'b0;
    endtask

    task automatic test_counter();
        axi_data_t d;
        axi_resp_t r;
        axi_read(ADDR_COUNT, d, r);
        check_eq("rdata", d, sent); // every accepted block leaves exactly once.
        axi_write(ADDR_CTRL, 32'h3, r);
        axi_read(ADDR_COUNT, d, r);
        check_eq("rdata", d, 32'h0);
    endtask

    initial begin
        void'($urandom(32'hcd0e_cbd6));
        arst_n   = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        in_valid = 1'b0;
        in_mant  = '0;
        in_exp   = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        test_registers();
        test_bypass();
        test_gelu();
        test_stream();
        test_counter();
        $display("%0d errors, %0d blocks transferred", errors, xfers);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/mxint_gelu_top.sv
`timescale 1ns/1ps

module mxint_gelu_top import mxint_gelu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,
    input  logic       in_valid,
    output logic       in_ready,
    input  man_block_t in_mant,
    input  exp_t       in_exp,
    output logic       out_valid,
    input  logic       out_ready,
    output man_block_t out_mant,
    output exp_t       out_exp
);

    logic gelu_en;
    logic block_done;

    mxint_gelu_csr u_csr (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .gelu_en    (gelu_en),
        .block_done (block_done)
    );

    mxint_gelu_core u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_mant    (in_mant),
        .in_exp     (in_exp),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_mant   (out_mant),
        .out_exp    (out_exp),
        .gelu_en    (gelu_en),
        .block_done (block_done)
    );

endmodule

// File: rtl/mxint_gelu_core.sv
`timescale 1ns/1ps

module mxint_gelu_core import mxint_gelu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  man_block_t in_mant,
    input  exp_t       in_exp,
    output logic       out_valid,
    input  logic       out_ready,
    output man_block_t out_mant,
    output exp_t       out_exp,
    input  logic       gelu_en,
    output logic       block_done
);

    fx_block_t elem_res;

    gelu_stream_if #(.MANT_W($bits(fx_block_t))) s1_if ();

    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_elem
        mxint_gelu_element u_elem (
            .mant    (man_t'(in_mant[i*MAN_WIDTH +: MAN_WIDTH])),
            .exp     (in_exp),
            .gelu_en (gelu_en),
            .y       (elem_res[i*FX_WIDTH +: FX_WIDTH])
        );
    end

    // stage 1 takes a block when empty or when the normaliser drains it.
    assign in_ready = !s1_if.valid || s1_if.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_if.valid <= 1'b0;
        end else if (in_ready) begin
            s1_if.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_if.mant <= elem_res;
            s1_if.exp  <= in_exp;
        end
    end

    mxint_block_norm u_norm (
        .clk       (clk),
        .arst_n    (arst_n),
        .blk_in    (s1_if.snk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_mant  (out_mant),
        .out_exp   (out_exp)
    );

    assign block_done = out_valid && out_ready;

    a_stage1_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> $stable(s1_if.mant) && $stable(s1_if.exp));

endmodule

// File: rtl/mxint_block_norm.sv
`timescale 1ns/1ps

module mxint_block_norm import mxint_gelu_pkg::*; (
    input  logic           clk,
    input  logic           arst_n,
    gelu_stream_if.snk     blk_in,
    output logic           out_valid,
    input  logic           out_ready,
    output man_block_t     out_mant,
    output exp_t           out_exp
);

    fx_t        res_in [BLOCK_SIZE];
    logic [3:0] norm_exp;
    man_block_t next_mant;

    always_comb begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            res_in[i] = fx_t'(blk_in.mant[i*FX_WIDTH +: FX_WIDTH]);
        end
    end

    // smallest exponent at which every element fits a mantissa.
    always_comb begin
        logic all_fit;
        logic found;
        fx_t  sh;
        found    = 1'b0;
        norm_exp = 4'(NORM_EXP_MAX);
        for (int e = 0; e <= NORM_EXP_MAX; e++) begin
            all_fit = 1'b1;
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                sh = res_in[i] >>> e;
                if ((sh > MAN_MAX) || (sh < MAN_MIN)) begin
                    all_fit = 1'b0;
                end
            end
            if (all_fit && !found) begin
                found    = 1'b1;
                norm_exp = 4'(e);
            end
        end
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            sh = res_in[i] >>> norm_exp;
            if (sh > MAN_MAX) begin
                sh = fx_t'(MAN_MAX); // only when nothing fits at the top exponent.
            end else if (sh < MAN_MIN) begin
                sh = fx_t'(MAN_MIN);
            end
            next_mant[i*MAN_WIDTH +: MAN_WIDTH] = sh[MAN_WIDTH-1:0];
        end
    end

    assign blk_in.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (blk_in.ready) begin
            out_valid <= blk_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_in.valid && blk_in.ready) begin
            out_mant <= next_mant;
            out_exp  <= exp_t'(norm_exp);
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_mant) && $stable(out_exp));

endmodule

// File: rtl/mxint_gelu_element.sv
`timescale 1ns/1ps

module mxint_gelu_element import mxint_gelu_pkg::*; (
    input  man_t mant,
    input  exp_t exp,
    input  logic gelu_en,
    output fx_t  y
);

    logic signed [31:0] mant_ext;
    logic signed [31:0] wide;
    logic [4:0]         amt;
    fx_t                fx;
    fx_t                gelu_y;

    always_comb begin
        mant_ext = mant;
        if (exp < 0) begin
            // beyond 8 only sign bits remain.
            amt  = (exp < -8) ? 5'd8 : 5'(-exp);
            wide = mant_ext >>> amt;
        end else begin
            amt  = (exp > 16) ? 5'd16 : 5'(exp); // any nonzero mantissa saturates at 16.
            wide = mant_ext <<< amt;
        end
    end

    always_comb begin
        if (wide > FX_MAX) begin
            fx = FX_MAX;
        end else if (wide < FX_MIN) begin
            fx = FX_MIN;
        end else begin
            fx = fx_t'(wide);
        end
    end

    gelu_approx u_gelu (
        .x (fx),
        .y (gelu_y)
    );

    assign y = gelu_en ? gelu_y : fx; // bypass keeps fx.

endmodule

// File: rtl/gelu_approx.sv
`timescale 1ns/1ps

// hard gelu in fx units: y = x * (x + 3) / 6 between the knees.
module gelu_approx import mxint_gelu_pkg::*; (
    input  fx_t x,
    output fx_t y
);

    logic signed [2*FX_WIDTH-1:0] xw;
    logic signed [2*FX_WIDTH-1:0] prod;
    logic signed [2*FX_WIDTH-1:0] quot;

    always_comb begin
        xw   = x;
        prod = xw * (xw + GELU_KNEE);
        quot = prod / (2 * GELU_KNEE); // 48 in fx units.
        // division truncates toward zero, step down for negative remainders.
        if ((prod < 0) && ((prod % (2 * GELU_KNEE)) != 0)) begin
            quot = quot - 1;
        end
    end

    always_comb begin
        if (x <= -GELU_KNEE) begin
            y = '0;
        end else if (x >= GELU_KNEE) begin
            y = x;
        end else begin
            y = fx_t'(quot); // magnitude stays below the knee here.
        end
    end

endmodule

// File: rtl/mxint_gelu_csr.sv
`timescale 1ns/1ps

module mxint_gelu_csr import mxint_gelu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,
    output logic      gelu_en,
    input  logic      block_done
);

    logic      wr_fire;
    logic      rd_fire;
    logic      ctrl_wr;
    logic      clear;
    axi_data_t count;
    axi_data_t ctrl_rd;

    // address and data are taken together, one outstanding response at a time.
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign rd_fire = arvalid && !rvalid;
    assign arready = rd_fire;

    assign ctrl_wr = wr_fire && (awaddr == ADDR_CTRL) && wstrb[0];
    assign clear   = ctrl_wr && wdata[CTRL_CLEAR_BIT];

    always_comb begin
        ctrl_rd                  = '0;
        ctrl_rd[CTRL_ENABLE_BIT] = gelu_en; // clear bit reads as zero.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gelu_en <= 1'b1;
        end else if (ctrl_wr) begin
            gelu_en <= wdata[CTRL_ENABLE_BIT];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (block_done && (count != '1)) begin
            count <= count + 1'b1; // saturates at all ones.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= ((awaddr == ADDR_CTRL) || (awaddr == ADDR_COUNT)) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr)
                ADDR_CTRL: begin
                    rdata <= ctrl_rd;
                    rresp <= RESP_OKAY;
                end
                ADDR_COUNT: begin
                    rdata <= count;
                    rresp <= RESP_OKAY;
                end
                default: begin
                    rdata <= '0;
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    // a write response only follows a completed write.
    a_bvalid_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(bvalid) |-> $past(wr_fire));

endmodule

// File: rtl/gelu_stream_if.sv
`timescale 1ns/1ps

// one block per beat, valid/ready.
// mant holds one mantissa block by default; the core widens it for fx results.
interface gelu_stream_if import mxint_gelu_pkg::*; #(
    parameter int MANT_W = $bits(man_block_t)
) ();

    logic              valid;
    logic              ready;
    logic [MANT_W-1:0] mant;
    exp_t              exp;

    modport src (
        output valid, mant, exp,
        input  ready
    );

    modport snk (
        input  valid, mant, exp,
        output ready
    );

endinterface

// File: rtl/mxint_gelu_pkg.sv
package mxint_gelu_pkg;

    // block geometry.
    localparam int BLOCK_SIZE = 4;
    localparam int MAN_WIDTH  = 8;
    localparam int EXP_WIDTH  = 8;

    // fixed point used between the element and the normaliser.
    localparam int FX_WIDTH = 16;
    localparam int FX_FRAC  = 3;

    typedef logic signed [MAN_WIDTH-1:0]          man_t;
    typedef logic signed [EXP_WIDTH-1:0]          exp_t;
    typedef logic signed [FX_WIDTH-1:0]           fx_t;
    typedef logic [BLOCK_SIZE*MAN_WIDTH-1:0]      man_block_t; // element 0 in the low byte.
    typedef logic [BLOCK_SIZE*FX_WIDTH-1:0]       fx_block_t;

    localparam man_t MAN_MAX = {1'b0, {(MAN_WIDTH-1){1'b1}}};
    localparam man_t MAN_MIN = {1'b1, {(MAN_WIDTH-1){1'b0}}};
    localparam fx_t  FX_MAX  = {1'b0, {(FX_WIDTH-1){1'b1}}};
    localparam fx_t  FX_MIN  = {1'b1, {(FX_WIDTH-1){1'b0}}};

    // 3.0 in fx units.
    localparam fx_t GELU_KNEE = fx_t'(3 << FX_FRAC);

    localparam int NORM_EXP_MAX = 8;

    // axi4-lite register map.
    localparam int AXI_ADDR_WIDTH = 4;
    localparam int AXI_DATA_WIDTH = 32;

    typedef logic [AXI_ADDR_WIDTH-1:0]   axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]   axi_data_t;
    typedef logic [AXI_DATA_WIDTH/8-1:0] axi_strb_t;
    typedef logic [1:0]                  axi_resp_t;

    localparam axi_addr_t ADDR_CTRL  = 4'h0;
    localparam axi_addr_t ADDR_COUNT = 4'h4;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage
